// File: common/hci_pkg.sv
//**********************************************************************
// HCI PIO shared definitions
//**********************************************************************

package hci_pkg;

  // Software data path
  localparam int unsigned DwordWidth = 32;
  localparam int unsigned CmdDwords = 2;  // Dwords per command

  typedef logic [DwordWidth-1:0] dword_t;
  typedef logic [CmdDwords*DwordWidth-1:0] cmd_t;  // Dword 0 in the low half

  // Register word addresses
  localparam int unsigned AddrWidth = 3;

  localparam logic [AddrWidth-1:0] AddrResetCtrl = 3'd0;
  localparam logic [AddrWidth-1:0] AddrThldCtrl = 3'd1;
  localparam logic [AddrWidth-1:0] AddrCmdPort = 3'd2;
  localparam logic [AddrWidth-1:0] AddrXferPort = 3'd3;
  localparam logic [AddrWidth-1:0] AddrRespPort = 3'd4;
  localparam logic [AddrWidth-1:0] AddrStatus = 3'd5;

  // RESET_CONTROL bit positions, one per queue
  localparam int unsigned RstCmd = 0;
  localparam int unsigned RstTx = 1;
  localparam int unsigned RstRx = 2;
  localparam int unsigned RstResp = 3;

  // Each QUEUE_THLD_CTRL field
  localparam int unsigned ThldWidth = 8;

endpackage : hci_pkg

// File: queue/hci_queue.sv
//**********************************************************************
// HCI show-ahead queue
//**********************************************************************

`timescale 1ns/1ps

module hci_queue #(
  parameter type T = logic,
  parameter int unsigned Depth = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  logic                          push_i,
  input  T                              data_i,
  input  logic                          pop_i,
  output T                              data_o,
  output logic                          empty_o,
  output logic                          full_o,
  input  logic [hci_pkg::ThldWidth-1:0] thld_i,
  output logic                          thld_reached_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned LvlWidth = $clog2(Depth + 1);

  T mem_q[Depth];
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [LvlWidth-1:0] level_q;
  logic do_push;
  logic do_pop;

  // Pointers wrap at Depth, which need not be a power of two
  function automatic logic [PtrWidth-1:0] ptr_inc(input logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty_o = (level_q == '0);
  assign full_o = (level_q == LvlWidth'(Depth));
  assign do_push = push_i && !full_o;  // Push on full is dropped
  assign do_pop = pop_i && !empty_o;
  assign data_o = mem_q[rd_ptr_q];  // Head shown before the pop
  assign thld_reached_o = 32'(level_q) >= 32'(thld_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      level_q <= '0;
    end else if (clear_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      level_q <= '0;
    end else begin
      if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (do_pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10: level_q <= level_q + 1'b1;
        2'b01: level_q <= level_q - 1'b1;
        default: level_q <= level_q;  // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push && !clear_i) mem_q[wr_ptr_q] <= data_i;
  end

endmodule : hci_queue

// File: design/hci_regs.sv
//**********************************************************************
// HCI PIO register block
//**********************************************************************

`timescale 1ns/1ps

module hci_regs #(
  parameter int unsigned DataDepth = 8,
  parameter int unsigned RespDepth = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          req_i,
  input  logic                          req_is_wr_i,
  input  logic [hci_pkg::AddrWidth-1:0] addr_i,
  input  hci_pkg::dword_t               wr_data_i,
  output logic                          rd_ack_o,
  output logic                          rd_err_o,
  output hci_pkg::dword_t               rd_data_o,
  output logic                          wr_ack_o,
  output logic                          wr_err_o,
  output logic [3:0]                    rst_req_o,
  input  logic [3:0]                    rst_done_i,
  output logic                          cmd_wr_o,
  output logic                          tx_push_o,
  output logic                          rx_pop_o,
  output logic                          resp_pop_o,
  output hci_pkg::dword_t               wr_data_o,
  input  logic                          cmd_busy_i,
  input  logic                          tx_full_i,
  input  logic                          rx_empty_i,
  input  logic                          resp_empty_i,
  input  logic                          cmd_empty_i,
  input  logic                          tx_empty_i,
  input  hci_pkg::dword_t               rx_data_i,
  input  hci_pkg::dword_t               resp_data_i,
  output logic [hci_pkg::ThldWidth-1:0] rx_thld_o,
  output logic [hci_pkg::ThldWidth-1:0] resp_thld_o,
  input  logic                          rx_thld_reached_i,
  input  logic                          resp_thld_reached_i
);

  localparam int unsigned TW = hci_pkg::ThldWidth;
  localparam logic [TW-1:0] RxThldMax = TW'(DataDepth - 1);
  localparam logic [TW-1:0] RespThldMax = TW'(RespDepth - 1);

  logic wr_req;
  logic rd_req;
  logic wr_err_d;
  logic rd_err_d;
  hci_pkg::dword_t rd_data_d;
  logic [3:0] rst_q;
  logic [3:0] rst_set;
  logic [TW-1:0] rx_thld_q;
  logic [TW-1:0] resp_thld_q;

  function automatic logic [TW-1:0] clamp(input logic [TW-1:0] val, input logic [TW-1:0] max);
    return (val > max) ? max : val;
  endfunction

  assign wr_req = req_i && req_is_wr_i;
  assign rd_req = req_i && !req_is_wr_i;

  // Error and read data for whatever address is presented
  always_comb begin
    wr_err_d = 1'b0;
    rd_err_d = 1'b0;
    rd_data_d = '0;
    case (addr_i)
      hci_pkg::AddrResetCtrl: rd_data_d = hci_pkg::DwordWidth'(rst_q);
      hci_pkg::AddrThldCtrl:  rd_data_d = hci_pkg::DwordWidth'({resp_thld_q, rx_thld_q});
      hci_pkg::AddrCmdPort: begin
        wr_err_d = cmd_busy_i || rst_q[hci_pkg::RstCmd];
        rd_err_d = 1'b1;  // Write-only port
      end
      hci_pkg::AddrXferPort: begin
        wr_err_d = tx_full_i || rst_q[hci_pkg::RstTx];
        rd_err_d = rx_empty_i;
        rd_data_d = rx_empty_i ? '0 : rx_data_i;
      end
      hci_pkg::AddrRespPort: begin
        wr_err_d = 1'b1;
        rd_err_d = resp_empty_i;
        rd_data_d = resp_empty_i ? '0 : resp_data_i;
      end
      hci_pkg::AddrStatus: begin
        wr_err_d = 1'b1;
        rd_data_d = hci_pkg::DwordWidth'({tx_full_i, resp_thld_reached_i, rx_thld_reached_i,
                                          tx_empty_i, cmd_empty_i});
      end
      default: begin
        wr_err_d = 1'b1;
        rd_err_d = 1'b1;
      end
    endcase
  end

  // Port strobes only fire for requests that will be acknowledged clean
  assign cmd_wr_o = wr_req && (addr_i == hci_pkg::AddrCmdPort) && !wr_err_d;
  assign tx_push_o = wr_req && (addr_i == hci_pkg::AddrXferPort) && !wr_err_d;
  assign rx_pop_o = rd_req && (addr_i == hci_pkg::AddrXferPort) && !rd_err_d;
  assign resp_pop_o = rd_req && (addr_i == hci_pkg::AddrRespPort) && !rd_err_d;
  assign wr_data_o = wr_data_i;

  assign rst_set = (wr_req && (addr_i == hci_pkg::AddrResetCtrl)) ? wr_data_i[3:0] : '0;
  assign rst_req_o = rst_q;
  assign rx_thld_o = rx_thld_q;
  assign resp_thld_o = resp_thld_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ack_o <= 1'b0;
      rd_err_o <= 1'b0;
      wr_ack_o <= 1'b0;
      wr_err_o <= 1'b0;
      rst_q <= '0;
      rx_thld_q <= clamp(TW'(1), RxThldMax);
      resp_thld_q <= clamp(TW'(1), RespThldMax);
    end else begin
      rd_ack_o <= rd_req;
      rd_err_o <= rd_req && rd_err_d;
      wr_ack_o <= wr_req;
      wr_err_o <= wr_req && wr_err_d;
      rst_q <= (rst_q & ~rst_done_i) | rst_set;  // A new request wins over done
      if (wr_req && (addr_i == hci_pkg::AddrThldCtrl)) begin
        rx_thld_q <= clamp(wr_data_i[TW-1:0], RxThldMax);
        resp_thld_q <= clamp(wr_data_i[2*TW-1:TW], RespThldMax);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_req) rd_data_o <= rd_data_d;
  end

endmodule : hci_regs

// File: design/hci_cmd_fsm.sv
//**********************************************************************
// HCI command assembly FSM
//**********************************************************************

`timescale 1ns/1ps

module hci_cmd_fsm (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            clear_i,
  input  logic            dword_wr_i,
  input  hci_pkg::dword_t dword_i,
  output logic            busy_o,
  input  logic            queue_full_i,
  output logic            push_o,
  output hci_pkg::cmd_t   cmd_o
);

  localparam int unsigned DW = hci_pkg::DwordWidth;

  typedef enum logic [1:0] {
    Idle,
    Collect,
    Push
  } state_e;

  state_e state_q;
  logic push_q;
  hci_pkg::cmd_t cmd_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
      push_q <= 1'b0;
    end else if (clear_i) begin
      // Queue reset drops a half-built command
      state_q <= Idle;
      push_q <= 1'b0;
    end else begin
      push_q <= 1'b0;
      case (state_q)
        Idle:    if (dword_wr_i) state_q <= Collect;
        Collect: if (dword_wr_i) state_q <= Push;
        Push: begin
          // Wait here while the command queue is full
          if (!queue_full_i) begin
            push_q <= 1'b1;
            state_q <= Idle;
          end
        end
        default: state_q <= Idle;
      endcase
    end
  end

  // Dword 0 goes low, dword 1 high
  always_ff @(posedge clk_i) begin
    if (dword_wr_i && (state_q == Idle)) cmd_q[0 +: DW] <= dword_i;
    if (dword_wr_i && (state_q == Collect)) cmd_q[DW +: DW] <= dword_i;
  end

  assign busy_o = (state_q == Push);
  assign push_o = push_q;
  assign cmd_o = cmd_q;  // Still stable in the push cycle

endmodule : hci_cmd_fsm

// File: design/hci_reset_timer.sv
//**********************************************************************
// HCI queue reset timer
//**********************************************************************

`timescale 1ns/1ps

module hci_reset_timer #(
  parameter int unsigned ResetHold = 4
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic req_i,
  output logic clear_o,
  output logic done_o
);

  localparam int unsigned CntWidth = (ResetHold > 1) ? $clog2(ResetHold) : 1;

  logic [CntWidth-1:0] cnt_q;
  logic active_q;
  logic done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
      active_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (active_q) begin
        if (cnt_q == '0) begin
          active_q <= 1'b0;
          done_q <= 1'b1;  // Clears the request bit
        end else begin
          cnt_q <= cnt_q - 1'b1;
        end
      end else if (req_i && !done_q) begin
        // Request bit is still high during the done cycle, so skip it
        active_q <= 1'b1;
        cnt_q <= CntWidth'(ResetHold - 1);
      end
    end
  end

  assign clear_o = active_q;
  assign done_o = done_q;

endmodule : hci_reset_timer

// File: design/i3c_pio_top.sv
//**********************************************************************
// I3C HCI PIO subsystem
//**********************************************************************

`timescale 1ns/1ps

module i3c_pio_top #(
  parameter int unsigned CmdDepth = 4,
  parameter int unsigned DataDepth = 8,
  parameter int unsigned RespDepth = 4,
  parameter int unsigned ResetHold = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Software register port
  input  logic                          req_i,
  input  logic                          req_is_wr_i,
  input  logic [hci_pkg::AddrWidth-1:0] addr_i,
  input  hci_pkg::dword_t               wr_data_i,
  output logic                          rd_ack_o,
  output logic                          rd_err_o,
  output hci_pkg::dword_t               rd_data_o,
  output logic                          wr_ack_o,
  output logic                          wr_err_o,
  // Bus controller side
  input  logic                          cmd_pop_i,
  output hci_pkg::cmd_t                 cmd_data_o,
  output logic                          cmd_empty_o,
  input  logic                          tx_pop_i,
  output hci_pkg::dword_t               tx_data_o,
  output logic                          tx_empty_o,
  input  logic                          rx_push_i,
  input  hci_pkg::dword_t               rx_data_i,
  output logic                          rx_full_o,
  input  logic                          resp_push_i,
  input  hci_pkg::dword_t               resp_data_i,
  output logic                          resp_full_o
);

  logic [3:0] rst_req;
  logic [3:0] rst_done;
  logic [3:0] q_clear;  // Indexed by RESET_CONTROL bit
  logic cmd_wr, tx_push, rx_pop, resp_pop;
  logic cmd_busy, cmd_push, cmd_full, tx_full;
  logic rx_empty, resp_empty;
  logic rx_thld_reached, resp_thld_reached;
  hci_pkg::dword_t wr_data, rx_head, resp_head;
  hci_pkg::cmd_t cmd_assembled;
  logic [hci_pkg::ThldWidth-1:0] rx_thld, resp_thld;

  hci_regs #(.DataDepth(DataDepth), .RespDepth(RespDepth)) hci_regs_i (
    .clk_i, .rst_ni, .req_i, .req_is_wr_i, .addr_i, .wr_data_i,
    .rd_ack_o, .rd_err_o, .rd_data_o, .wr_ack_o, .wr_err_o,
    .rst_req_o(rst_req), .rst_done_i(rst_done),
    .cmd_wr_o(cmd_wr), .tx_push_o(tx_push), .rx_pop_o(rx_pop), .resp_pop_o(resp_pop),
    .wr_data_o(wr_data), .cmd_busy_i(cmd_busy),
    .tx_full_i(tx_full), .rx_empty_i(rx_empty), .resp_empty_i(resp_empty),
    .cmd_empty_i(cmd_empty_o), .tx_empty_i(tx_empty_o),
    .rx_data_i(rx_head), .resp_data_i(resp_head),
    .rx_thld_o(rx_thld), .resp_thld_o(resp_thld),
    .rx_thld_reached_i(rx_thld_reached), .resp_thld_reached_i(resp_thld_reached)
  );

  hci_cmd_fsm hci_cmd_fsm_i (
    .clk_i, .rst_ni, .clear_i(q_clear[hci_pkg::RstCmd]),
    .dword_wr_i(cmd_wr), .dword_i(wr_data), .busy_o(cmd_busy),
    .queue_full_i(cmd_full), .push_o(cmd_push), .cmd_o(cmd_assembled)
  );

  // One timer per RESET_CONTROL bit
  for (genvar i = 0; i < 4; i++) begin : g_rst_timer
    hci_reset_timer #(.ResetHold(ResetHold)) hci_reset_timer_i (
      .clk_i, .rst_ni, .req_i(rst_req[i]), .clear_o(q_clear[i]), .done_o(rst_done[i])
    );
  end

  hci_queue #(.T(hci_pkg::cmd_t), .Depth(CmdDepth)) cmd_queue_i (
    .clk_i, .rst_ni, .clear_i(q_clear[hci_pkg::RstCmd]),
    .push_i(cmd_push), .data_i(cmd_assembled), .pop_i(cmd_pop_i), .data_o(cmd_data_o),
    .empty_o(cmd_empty_o), .full_o(cmd_full), .thld_i('0), .thld_reached_o()
  );

  hci_queue #(.T(hci_pkg::dword_t), .Depth(DataDepth)) tx_queue_i (
    .clk_i, .rst_ni, .clear_i(q_clear[hci_pkg::RstTx]),
    .push_i(tx_push), .data_i(wr_data), .pop_i(tx_pop_i), .data_o(tx_data_o),
    .empty_o(tx_empty_o), .full_o(tx_full), .thld_i('0), .thld_reached_o()
  );

  hci_queue #(.T(hci_pkg::dword_t), .Depth(DataDepth)) rx_queue_i (
    .clk_i, .rst_ni, .clear_i(q_clear[hci_pkg::RstRx]),
    .push_i(rx_push_i), .data_i(rx_data_i), .pop_i(rx_pop), .data_o(rx_head),
    .empty_o(rx_empty), .full_o(rx_full_o), .thld_i(rx_thld),
    .thld_reached_o(rx_thld_reached)
  );

  hci_queue #(.T(hci_pkg::dword_t), .Depth(RespDepth)) resp_queue_i (
    .clk_i, .rst_ni, .clear_i(q_clear[hci_pkg::RstResp]),
    .push_i(resp_push_i), .data_i(resp_data_i), .pop_i(resp_pop), .data_o(resp_head),
    .empty_o(resp_empty), .full_o(resp_full_o), .thld_i(resp_thld),
    .thld_reached_o(resp_thld_reached)
  );

endmodule : i3c_pio_top

// File: bench/tb_i3c_pio_top.sv
//**********************************************************************
// I3C PIO random testbench
//**********************************************************************

`timescale 1ns/1ps

module tb_i3c_pio_top;

  localparam int CmdDepth = 4;
  localparam int DataDepth = 8;
  localparam int RespDepth = 4;
  localparam int NumOps = 400;
  localparam int WaitLimit = 20;  // Bound on every polling loop

  logic clk_i = 1'b0;
  logic rst_ni;
  logic req_i, req_is_wr_i;
  logic [hci_pkg::AddrWidth-1:0] addr_i;
  hci_pkg::dword_t wr_data_i, rd_data_o, tx_data_o, rx_data_i, resp_data_i;
  logic rd_ack_o, rd_err_o, wr_ack_o, wr_err_o;
  logic cmd_pop_i, cmd_empty_o, tx_pop_i, tx_empty_o;
  logic rx_push_i, rx_full_o, resp_push_i, resp_full_o;
  hci_pkg::cmd_t cmd_data_o;

  // Reference model state
  hci_pkg::cmd_t cmd_mq[$];
  hci_pkg::dword_t tx_mq[$], rx_mq[$], resp_mq[$];
  hci_pkg::dword_t half_dw;  // Dword 0 of a command being collected
  hci_pkg::cmd_t pend_cmd;   // Finished command waiting on a full queue
  logic has_half, has_pend;
  int rx_thld, resp_thld;
  int errors = 0;
  int seed = 32'h41dedafc;
  hci_pkg::dword_t last_rd;

  i3c_pio_top i3c_pio_top_i (.*);

  always #5 clk_i = ~clk_i;

  initial begin : watchdog
    repeat (NumOps * 20) @(posedge clk_i);
    $display("Watchdog timeout: the test sequence did not finish in time");
    $display("ERRORS FOUND");
    $finish;
  end

  task automatic report_error(input string msg);
    $display("Error at %0t: %s", $time, msg);
    errors++;
  endtask

  function automatic int limit_to(input int val, input int max);
    return (val > max) ? max : val;
  endfunction

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk_i);
      if (rd_ack_o || wr_ack_o) report_error("acknowledge without a request");
    end
  endtask

  // One request, checked on the next cycle
  task automatic sw_access(input logic wr, input logic [2:0] addr, input hci_pkg::dword_t data,
                           input logic exp_err, input hci_pkg::dword_t exp_data,
                           input logic chk_data);
    req_i = 1'b1;
    req_is_wr_i = wr;
    addr_i = addr;
    wr_data_i = data;
    @(negedge clk_i);
    req_i = 1'b0;
    if (rd_ack_o !== !wr || wr_ack_o !== wr)
      report_error($sformatf("ack rd %b wr %b for addr %0d", rd_ack_o, wr_ack_o, addr));
    if (rd_err_o !== (!wr && exp_err) || wr_err_o !== (wr && exp_err))
      report_error($sformatf("err rd %b wr %b, expected %b", rd_err_o, wr_err_o, exp_err));
    if (!wr && chk_data && rd_data_o !== exp_data)
      report_error($sformatf("addr %0d read %h, expected %h", addr, rd_data_o, exp_data));
    last_rd = rd_data_o;
  endtask

  task automatic ctrl_strobe(input int which, input hci_pkg::dword_t data);
    cmd_pop_i = (which == 0);
    tx_pop_i = (which == 1);
    rx_push_i = (which == 2);
    resp_push_i = (which == 3);
    rx_data_i = data;
    resp_data_i = data;
    @(negedge clk_i);
    cmd_pop_i = 1'b0;
    tx_pop_i = 1'b0;
    rx_push_i = 1'b0;
    resp_push_i = 1'b0;
  endtask

  task automatic cmd_write(input hci_pkg::dword_t d);
    sw_access(1'b1, hci_pkg::AddrCmdPort, d, has_pend, '0, 1'b0);
    if (!has_pend) begin
      if (!has_half) begin
        half_dw = d;
        has_half = 1'b1;
      end else begin
        has_half = 1'b0;
        if (cmd_mq.size() < CmdDepth) cmd_mq.push_back({d, half_dw});
        else begin
          pend_cmd = {d, half_dw};  // Held until the controller pops
          has_pend = 1'b1;
        end
      end
    end
  endtask

  task automatic pop_cmd();
    int waited;
    waited = 0;
    if (cmd_mq.size() > 0) begin
      while (cmd_empty_o && waited < WaitLimit) begin
        @(negedge clk_i);
        waited++;
      end
      if (cmd_empty_o) report_error("command never reached the head of the queue");
      else if (cmd_data_o !== cmd_mq[0])
        report_error($sformatf("command %h, expected %h", cmd_data_o, cmd_mq[0]));
      void'(cmd_mq.pop_front());
      if (has_pend) begin
        cmd_mq.push_back(pend_cmd);
        has_pend = 1'b0;
      end
    end else if (!cmd_empty_o) report_error("command queue not empty");
    ctrl_strobe(0, '0);
  endtask

  task automatic pop_tx();
    if (tx_mq.size() > 0) begin
      if (tx_empty_o || tx_data_o !== tx_mq[0])
        report_error($sformatf("TX head %h, expected %h", tx_data_o, tx_mq[0]));
      void'(tx_mq.pop_front());
    end else if (!tx_empty_o) report_error("TX queue not empty");
    ctrl_strobe(1, '0);
  endtask

  task automatic push_rx(input hci_pkg::dword_t d);
    if (rx_full_o !== (rx_mq.size() == DataDepth)) report_error("rx_full_o mismatch");
    if (rx_mq.size() < DataDepth) rx_mq.push_back(d);  // Lost when full
    ctrl_strobe(2, d);
  endtask

  task automatic push_resp(input hci_pkg::dword_t d);
    if (resp_full_o !== (resp_mq.size() == RespDepth)) report_error("resp_full_o mismatch");
    if (resp_mq.size() < RespDepth) resp_mq.push_back(d);
    ctrl_strobe(3, d);
  endtask

  // Empty read returns 0 with an error
  task automatic read_rx();
    hci_pkg::dword_t exp;
    logic empty;
    exp = '0;
    empty = rx_mq.size() == 0;
    if (!empty) exp = rx_mq.pop_front();
    sw_access(1'b0, hci_pkg::AddrXferPort, '0, empty, exp, 1'b1);
  endtask

  task automatic read_status();
    hci_pkg::dword_t exp;
    exp = '0;
    exp[0] = cmd_mq.size() == 0;
    exp[1] = tx_mq.size() == 0;
    exp[2] = rx_mq.size() >= rx_thld;
    exp[3] = resp_mq.size() >= resp_thld;
    exp[4] = tx_mq.size() == DataDepth;
    sw_access(1'b0, hci_pkg::AddrStatus, '0, 1'b0, exp, 1'b1);
  endtask

  task automatic queue_reset(input int bitpos);
    hci_pkg::dword_t mask;
    int polls;
    mask = '0;
    mask[bitpos] = 1'b1;
    polls = 0;
    sw_access(1'b1, hci_pkg::AddrResetCtrl, mask, 1'b0, '0, 1'b0);
    last_rd = mask;
    while (last_rd[bitpos] && polls < WaitLimit) begin
      sw_access(1'b0, hci_pkg::AddrResetCtrl, '0, 1'b0, '0, 1'b0);
      if ((last_rd & ~mask) != '0) report_error("unexpected RESET_CONTROL bits set");
      polls++;
    end
    if (last_rd[bitpos]) report_error("RESET_CONTROL bit never cleared");
    case (bitpos)
      hci_pkg::RstCmd: begin
        cmd_mq.delete();
        has_half = 1'b0;  // Next two dwords form a fresh command
        has_pend = 1'b0;
      end
      hci_pkg::RstTx: tx_mq.delete();
      hci_pkg::RstRx: rx_mq.delete();
      default: resp_mq.delete();
    endcase
    read_status();
  endtask

  initial begin : stimulus
    int sel;
    hci_pkg::dword_t d;
    logic full;
    rst_ni = 1'b0;
    req_i = 1'b0;
    req_is_wr_i = 1'b0;
    addr_i = '0;
    wr_data_i = '0;
    cmd_pop_i = 1'b0;
    tx_pop_i = 1'b0;
    rx_push_i = 1'b0;
    resp_push_i = 1'b0;
    rx_data_i = '0;
    resp_data_i = '0;
    has_half = 1'b0;
    has_pend = 1'b0;
    rx_thld = 1;
    resp_thld = 1;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    read_status();
    sw_access(1'b0, hci_pkg::AddrThldCtrl, '0, 1'b0, 32'h0101, 1'b1);
    for (int i = 0; i < NumOps; i++) begin
      sel = $unsigned($random(seed)) % 16;
      d = $random(seed);
      case (sel)
        0, 1, 2: cmd_write(d);
        3, 4: begin
          full = tx_mq.size() == DataDepth;
          sw_access(1'b1, hci_pkg::AddrXferPort, d, full, '0, 1'b0);
          if (!full) tx_mq.push_back(d);  // Dropped data never reaches the head
        end
        5: read_rx();
        6: begin
          full = resp_mq.size() == 0;
          sw_access(1'b0, hci_pkg::AddrRespPort, '0, full, full ? '0 : resp_mq[0], 1'b1);
          if (!full) void'(resp_mq.pop_front());
        end
        7, 14: push_rx(d);
        8: push_resp(d);
        9: pop_cmd();
        10: pop_tx();
        12: begin
          d = d & 32'h0000_0f0f;
          sw_access(1'b1, hci_pkg::AddrThldCtrl, d, 1'b0, '0, 1'b0);
          rx_thld = limit_to(int'(d[7:0]), DataDepth - 1);
          resp_thld = limit_to(int'(d[15:8]), RespDepth - 1);
          sw_access(1'b0, hci_pkg::AddrThldCtrl, '0, 1'b0, resp_thld * 256 + rx_thld, 1'b1);
        end
        13: begin
          case (d[2:1])
            2'd0: sw_access(1'b0, d[0] ? 3'd7 : 3'd6, '0, 1'b1, '0, 1'b1);
            2'd1: sw_access(1'b1, d[0] ? 3'd7 : 3'd6, d, 1'b1, '0, 1'b0);
            2'd2: sw_access(1'b0, hci_pkg::AddrCmdPort, '0, 1'b1, '0, 1'b1);
            default: sw_access(1'b0, hci_pkg::AddrResetCtrl, '0, 1'b0, '0, 1'b1);
          endcase
        end
        15: begin
          if (d[4:3] == 2'd0) queue_reset(int'(d[1:0]));
          else read_status();
        end
        default: read_status();
      endcase
      idle(3);  // Let the command FSM settle
    end
    $display("Test finished with %0d errors", errors);
    if (errors == 0) $display("NO ERRORS");
    else $display("ERRORS FOUND");
    $finish;
  end

endmodule : tb_i3c_pio_top

// File: i3c_pio_top.f
common/hci_pkg.sv
queue/hci_queue.sv
design/hci_regs.sv
design/hci_cmd_fsm.sv
design/hci_reset_timer.sv
design/i3c_pio_top.sv
bench/tb_i3c_pio_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the I3C PIO testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f i3c_pio_top.f --top-module tb_i3c_pio_top -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "NO ERRORS"; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
